// ==== bench/rob_tb.sv ====
// testbench for the reorder buffer back end
// drives dispatch and completion on the falling edge and checks every retire
// pulse, free-list order and final arf contents against a queue model

`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

    localparam int          CLK_PERIOD     = 4;                // ns
    localparam logic [31:0] SEED           = 32'h7db653ea;
    localparam int          N_RANDOM       = 40;               // in-order retirement test
    localparam int          N_PAIR         = 2;                // two-wide retirement test
    localparam int          N_FULL         = ROB_DEPTH + 1;    // one more than fits
    localparam int          TOTAL_INSTS    = N_RANDOM + N_PAIR + N_FULL;
    localparam int          TIMEOUT_CYCLES = 20 * TOTAL_INSTS;

    typedef struct packed {
        logic [AREG_W-1:0] areg;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] pc;
        logic [PREG_W-1:0] freed;
    } retire_t;

    logic                 clk, rstn;
    logic                 disp_valid, disp_ready;
    logic [AREG_W-1:0]    disp_areg;
    logic [DATA_W-1:0]    disp_pc;
    logic [PREG_W-1:0]    disp_preg;
    logic [ROB_IDX_W-1:0] disp_rob_idx;
    logic                 comp_valid_0, comp_valid_1;
    logic [ROB_IDX_W-1:0] comp_idx_0, comp_idx_1;
    logic [DATA_W-1:0]    comp_data_0, comp_data_1;
    logic                 ret_valid_0, ret_valid_1;
    logic [AREG_W-1:0]    ret_areg_0, ret_areg_1;
    logic [DATA_W-1:0]    ret_data_0, ret_data_1, ret_pc_0, ret_pc_1;
    logic [AREG_W-1:0]    rd_areg;
    logic [DATA_W-1:0]    rd_data;

    ////////////////////////////////
    // program and model state
    ////////////////////////////////
    logic [AREG_W-1:0] prog_areg [TOTAL_INSTS];
    logic [DATA_W-1:0] prog_pc   [TOTAL_INSTS];
    logic [DATA_W-1:0] prog_data [TOTAL_INSTS];  // value its completion carries
    logic [PREG_W-1:0] model_old [TOTAL_INSTS];  // preg displaced at dispatch
    logic [PREG_W-1:0] map_model [NUM_AREGS];
    logic [DATA_W-1:0] arf_model [NUM_AREGS];
    logic [PREG_W-1:0] free_q [$];
    int                pending [$];              // dispatched, not yet completed
    int                disp_seq    = 0;
    int                ret_seq     = 0;
    int                pend_next   = 0;
    int                cycles      = 0;

    rob_core_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] want);
        if (got !== want) begin
            stop_on_failure($sformatf("error at %0t: %s is %0h, expected %0h",
                                      $time, name, got, want));
        end
    endtask

    // expected retire of one instruction, also commits it into the model
    function automatic retire_t retire_model(input int seq);
        retire_t r;
        r.areg  = prog_areg[seq];
        r.data  = prog_data[seq];
        r.pc    = prog_pc[seq];
        r.freed = model_old[seq];
        arf_model[r.areg] = r.data;            // lane 1 runs second, younger wins
        free_q.push_back(r.freed);
        return r;
    endfunction

    // fixed_areg below zero picks random aregs, areg 31 is kept for the pair test
    task automatic make_program(input int first, input int num, input int fixed_areg);
        for (int i = first; i < first + num; i++) begin
            if (fixed_areg >= 0) prog_areg[i] = AREG_W'(fixed_areg);
            else prog_areg[i] = AREG_W'($urandom % (NUM_AREGS - 1));
            prog_pc[i]   = 32'h1000 + 32'(i * 4);
            prog_data[i] = $urandom;
        end
    endtask

    task automatic drive_completion(input int port, input int seq);
        if (port == 0) begin
            comp_valid_0 = 1'b1;
            comp_idx_0   = ROB_IDX_W'(seq % ROB_DEPTH);
            comp_data_0  = prog_data[seq];
        end else begin
            comp_valid_1 = 1'b1;
            comp_idx_1   = ROB_IDX_W'(seq % ROB_DEPTH);
            comp_data_1  = prog_data[seq];
        end
    endtask

    // one falling edge of stimulus, dispatch holds until accepted
    task automatic run_cycle(input int limit, input bit allow_comp, input bit gappy);
        int pick;
        @(negedge clk);
        while (pend_next < disp_seq) begin
            pending.push_back(pend_next);
            pend_next++;
        end
        disp_valid   = 1'b0;
        comp_valid_0 = 1'b0;
        comp_valid_1 = 1'b0;
        if (disp_seq < limit && (!gappy || ($urandom % 4) != 0)) begin
            disp_valid = 1'b1;
            disp_areg  = prog_areg[disp_seq];
            disp_pc    = prog_pc[disp_seq];
        end
        if (allow_comp) begin
            for (int port = 0; port < 2; port++) begin
                if (pending.size() > 0 && ($urandom % 2) == 0) begin
                    pick = int'($urandom % pending.size());
                    drive_completion(port, pending[pick]);
                    pending.delete(pick);
                end
            end
        end
    endtask

    ////////////////////////////////
    // compare process
    ////////////////////////////////
    always @(posedge clk) begin
        retire_t want;
        if (rstn) begin
            if (ret_valid_1 && !ret_valid_0) begin
                stop_on_failure("retire lane 1 pulsed without lane 0");
            end
            if (ret_valid_0 && ret_seq >= disp_seq) begin
                stop_on_failure("retire pulse with nothing in flight");
            end
            if (ret_valid_0) begin
                want = retire_model(ret_seq);
                check_value("ret_areg_0", 32'(ret_areg_0), 32'(want.areg));
                check_value("ret_data_0", ret_data_0, want.data);
                check_value("ret_pc_0", ret_pc_0, want.pc);
                ret_seq++;
            end
            if (ret_valid_1) begin
                want = retire_model(ret_seq);
                check_value("ret_areg_1", 32'(ret_areg_1), 32'(want.areg));
                check_value("ret_data_1", ret_data_1, want.data);
                check_value("ret_pc_1", ret_pc_1, want.pc);
                ret_seq++;
            end
            if (disp_valid && disp_ready) begin
                check_value("disp_preg", 32'(disp_preg), 32'(free_q[0]));
                check_value("disp_rob_idx", 32'(disp_rob_idx), 32'(disp_seq % ROB_DEPTH));
                model_old[disp_seq]  = map_model[disp_areg];
                map_model[disp_areg] = free_q.pop_front();
                disp_seq++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            stop_on_failure($sformatf("run hung: still busy after %0d cycles", cycles));
    end

    ////////////////////////////////
    // test sequence
    ////////////////////////////////
    initial begin
        void'($urandom(SEED));
        rstn         = 1'b0;
        disp_valid   = 1'b0;
        disp_areg    = '0;
        disp_pc      = '0;
        comp_valid_0 = 1'b0;
        comp_idx_0   = '0;
        comp_data_0  = '0;
        comp_valid_1 = 1'b0;
        comp_idx_1   = '0;
        comp_data_1  = '0;
        rd_areg      = '0;
        for (int i = 0; i < NUM_AREGS; i++) begin
            map_model[i] = PREG_W'(i);         // identity map out of reset
            arf_model[i] = '0;
            free_q.push_back(PREG_W'(NUM_AREGS + i));
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // random completion order on both ports
        make_program(0, N_RANDOM, -1);
        while (ret_seq < N_RANDOM) run_cycle(N_RANDOM, 1'b1, 1'b1);

        // two adjacent head entries complete in the same cycle
        make_program(N_RANDOM, N_PAIR, NUM_AREGS - 1);
        while (disp_seq < N_RANDOM + N_PAIR) run_cycle(N_RANDOM + N_PAIR, 1'b0, 1'b0);
        run_cycle(N_RANDOM + N_PAIR, 1'b0, 1'b0);
        drive_completion(1, N_RANDOM);         // older entry on port 1
        drive_completion(0, N_RANDOM + 1);
        pending.delete();
        run_cycle(N_RANDOM + N_PAIR, 1'b0, 1'b0);
        @(posedge clk);                        // retire edge
        @(negedge clk);
        check_value("ret_valid_0", 32'(ret_valid_0), 32'd1);
        check_value("ret_valid_1", 32'(ret_valid_1), 32'd1);

        // fill the rob, then hold one more dispatch
        make_program(N_RANDOM + N_PAIR, N_FULL, -1);
        while (disp_seq < N_RANDOM + N_PAIR + ROB_DEPTH) run_cycle(TOTAL_INSTS, 1'b0, 1'b0);
        repeat (4) begin
            run_cycle(TOTAL_INSTS, 1'b0, 1'b0);
            check_value("disp_ready", 32'(disp_ready), 32'd0);
            check_value("dispatch count", disp_seq, N_RANDOM + N_PAIR + ROB_DEPTH);
        end
        drive_completion(0, N_RANDOM + N_PAIR);  // head only
        void'(pending.pop_front());
        while (disp_seq < TOTAL_INSTS) run_cycle(TOTAL_INSTS, 1'b0, 1'b0);
        while (ret_seq < TOTAL_INSTS) run_cycle(TOTAL_INSTS, 1'b1, 1'b0);

        // committed state through the read port
        for (int a = 0; a < NUM_AREGS; a++) begin
            @(negedge clk);
            rd_areg = AREG_W'(a);
            @(posedge clk);
            check_value($sformatf("rd_data[%0d]", a), rd_data, arf_model[a]);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== design/arch_regfile.sv ====
// architectural register file, committed state only
// two write ports driven by rob retirement, lane 1 is younger
// one combinational read port for inspection

`timescale 1ns/1ps

module arch_regfile import rob_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              we_0,
    input  logic [AREG_W-1:0] wr_areg_0,
    input  logic [DATA_W-1:0] wr_data_0,
    input  logic              we_1,
    input  logic [AREG_W-1:0] wr_areg_1,
    input  logic [DATA_W-1:0] wr_data_1,
    input  logic [AREG_W-1:0] rd_areg,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] regs [NUM_AREGS];

    assign rd_data = regs[rd_areg];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we_0) regs[wr_areg_0] <= wr_data_0;
            if (we_1) regs[wr_areg_1] <= wr_data_1; // younger wins on a clash
        end
    end

endmodule

// ==== design/free_list.sv ====
// free physical register FIFO
// one pop per dispatch, up to two pushes from retirement per cycle
// reset contents are the pregs above the identity map, ascending

`timescale 1ns/1ps

module free_list import rob_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              pop,
    input  logic              push_0,
    input  logic              push_1,
    input  logic [PREG_W-1:0] push_preg_0,
    input  logic [PREG_W-1:0] push_preg_1,
    output logic [PREG_W-1:0] head_preg
);

    logic [PREG_W-1:0]     mem [FREE_DEPTH];
    logic [FREE_PTR_W-1:0] rd_ptr;
    logic [FREE_PTR_W-1:0] wr_ptr;
    logic [FREE_CNT_W-1:0] count;
    logic [FREE_PTR_W-1:0] wr_ptr_1;           // slot for the younger push

    // younger lane lands behind the older one when both push
    assign wr_ptr_1  = wr_ptr + FREE_PTR_W'(push_0);
    assign head_preg = mem[rd_ptr];

    // reset loads pregs NUM_AREGS and up
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                mem[i] <= PREG_W'(NUM_AREGS + i);
            end
        end else begin
            if (push_0) mem[wr_ptr] <= push_preg_0;
            if (push_1) mem[wr_ptr_1] <= push_preg_1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;                      // full, wraps onto rd_ptr
            count  <= FREE_CNT_W'(FREE_DEPTH);
        end else begin
            rd_ptr <= rd_ptr + FREE_PTR_W'(pop);
            wr_ptr <= wr_ptr + FREE_PTR_W'(push_0) + FREE_PTR_W'(push_1);
            count  <= count + FREE_CNT_W'(push_0) + FREE_CNT_W'(push_1)
                    - FREE_CNT_W'(pop);
        end
    end

    ////////////////////////////////
    // checks
    ////////////////////////////////

    // the rob limits in-flight renames, so the list never drains
    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rstn) pop |-> (count != '0)
    ) else $error("free list popped while empty");

    // returned pregs can only be ones handed out earlier
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rstn) count <= FREE_CNT_W'(FREE_DEPTH)
    ) else $error("free list count above capacity");

endmodule

// ==== design/rename_map.sv ====
// architectural to physical rename table
// reports the mapping displaced by a dispatch and installs the new preg
// on the dispatch edge, reset state is the identity map

`timescale 1ns/1ps

module rename_map import rob_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              rename_en,
    input  logic [AREG_W-1:0] rename_areg,
    input  logic [PREG_W-1:0] new_preg,
    output logic [PREG_W-1:0] old_preg
);

    logic [PREG_W-1:0] map_tbl [NUM_AREGS];

    // displaced mapping, goes to the rob for freeing at retire
    assign old_preg = map_tbl[rename_areg];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_tbl[i] <= PREG_W'(i);      // areg n -> preg n
            end
        end else if (rename_en) begin
            map_tbl[rename_areg] <= new_preg;
        end
    end

endmodule

// ==== design/reorder_buffer.sv ====
// in-order entry store for the back end
// dispatch writes the tail, two completion ports mark entries done,
// and up to two done entries leave from the head each cycle
// retire and free-return outputs are registered; arf writes land on the same edge

`timescale 1ns/1ps

module reorder_buffer import rob_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    // dispatch
    input  logic                 disp_en,
    input  logic [AREG_W-1:0]    disp_areg,
    input  logic [PREG_W-1:0]    disp_old_preg,
    input  logic [DATA_W-1:0]    disp_pc,
    output logic                 not_full,
    output logic [ROB_IDX_W-1:0] tail_idx,
    // completion
    input  logic                 comp_valid_0,
    input  logic [ROB_IDX_W-1:0] comp_idx_0,
    input  logic [DATA_W-1:0]    comp_data_0,
    input  logic                 comp_valid_1,
    input  logic [ROB_IDX_W-1:0] comp_idx_1,
    input  logic [DATA_W-1:0]    comp_data_1,
    // retirement, lane 0 is older
    output logic                 ret_valid_0,
    output logic [AREG_W-1:0]    ret_areg_0,
    output logic [DATA_W-1:0]    ret_data_0,
    output logic [DATA_W-1:0]    ret_pc_0,
    output logic                 ret_valid_1,
    output logic [AREG_W-1:0]    ret_areg_1,
    output logic [DATA_W-1:0]    ret_data_1,
    output logic [DATA_W-1:0]    ret_pc_1,
    // free list return
    output logic                 free_push_0,
    output logic [PREG_W-1:0]    free_preg_0,
    output logic                 free_push_1,
    output logic [PREG_W-1:0]    free_preg_1,
    // arf write ports
    output logic                 arf_we_0,
    output logic [AREG_W-1:0]    arf_areg_0,
    output logic [DATA_W-1:0]    arf_data_0,
    output logic                 arf_we_1,
    output logic [AREG_W-1:0]    arf_areg_1,
    output logic [DATA_W-1:0]    arf_data_1
);

    ////////////////////////////////
    // entry state
    ////////////////////////////////
    logic [ROB_DEPTH-1:0] occ;                 // slot holds an instruction
    logic [ROB_DEPTH-1:0] done;                // result written
    logic [AREG_W-1:0]    ent_areg     [ROB_DEPTH];
    logic [PREG_W-1:0]    ent_old_preg [ROB_DEPTH];
    logic [DATA_W-1:0]    ent_pc       [ROB_DEPTH];
    logic [DATA_W-1:0]    ent_data     [ROB_DEPTH];

    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] head_1;              // entry behind the head
    logic [ROB_IDX_W-1:0] tail;
    logic [ROB_CNT_W-1:0] count;

    logic                   retire_0;
    logic                   retire_1;
    logic [$clog2(RETIRE_W):0] num_ret;

    assign not_full = (count != ROB_CNT_W'(ROB_DEPTH));
    assign tail_idx = tail;
    assign head_1   = head + 1'b1;

    // stop at the first incomplete entry, lane 1 needs lane 0
    assign retire_0 = occ[head] && done[head];
    assign retire_1 = retire_0 && occ[head_1] && done[head_1];
    assign num_ret  = {1'b0, retire_0} + {1'b0, retire_1};

    // arf sees the retire decision itself, so it updates with ret_*
    assign arf_we_0   = retire_0;
    assign arf_areg_0 = ent_areg[head];
    assign arf_data_0 = ent_data[head];
    assign arf_we_1   = retire_1;
    assign arf_areg_1 = ent_areg[head_1];
    assign arf_data_1 = ent_data[head_1];

    // pregs go back on the same flop as the retire pulse
    assign free_push_0 = ret_valid_0;
    assign free_push_1 = ret_valid_1;

    ////////////////////////////////
    // control
    ////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            occ         <= '0;
            done        <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            ret_valid_0 <= 1'b0;
            ret_valid_1 <= 1'b0;
        end else begin
            // retiring slots never overlap the tail or a completion target
            if (retire_0) begin
                occ[head]  <= 1'b0;
                done[head] <= 1'b0;
            end
            if (retire_1) begin
                occ[head_1]  <= 1'b0;
                done[head_1] <= 1'b0;
            end
            if (disp_en) begin
                occ[tail]  <= 1'b1;
                done[tail] <= 1'b0;
            end
            if (comp_valid_0) done[comp_idx_0] <= 1'b1;
            if (comp_valid_1) done[comp_idx_1] <= 1'b1;

            head  <= head + ROB_IDX_W'(num_ret);
            tail  <= tail + ROB_IDX_W'(disp_en);
            count <= count + ROB_CNT_W'(disp_en) - ROB_CNT_W'(num_ret);

            ret_valid_0 <= retire_0;
            ret_valid_1 <= retire_1;
        end
    end

    ////////////////////////////////
    // payload
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (disp_en) begin
            ent_areg[tail]     <= disp_areg;
            ent_old_preg[tail] <= disp_old_preg;
            ent_pc[tail]       <= disp_pc;
        end
        if (comp_valid_0) ent_data[comp_idx_0] <= comp_data_0;
        if (comp_valid_1) ent_data[comp_idx_1] <= comp_data_1;

        if (retire_0) begin
            ret_areg_0  <= ent_areg[head];
            ret_data_0  <= ent_data[head];
            ret_pc_0    <= ent_pc[head];
            free_preg_0 <= ent_old_preg[head];
        end
        if (retire_1) begin
            ret_areg_1  <= ent_areg[head_1];
            ret_data_1  <= ent_data[head_1];
            ret_pc_1    <= ent_pc[head_1];
            free_preg_1 <= ent_old_preg[head_1];
        end
    end

    ////////////////////////////////
    // checks
    ////////////////////////////////

    // completions must name a live entry that has not finished yet
    a_comp_live_0 : assert property (
        @(posedge clk) disable iff (!rstn)
        comp_valid_0 |-> (occ[comp_idx_0] && !done[comp_idx_0])
    ) else $error("completion port 0 hit a free or finished entry");

    a_comp_live_1 : assert property (
        @(posedge clk) disable iff (!rstn)
        comp_valid_1 |-> (occ[comp_idx_1] && !done[comp_idx_1])
    ) else $error("completion port 1 hit a free or finished entry");

    // top gates dispatch with not_full
    a_disp_not_full : assert property (
        @(posedge clk) disable iff (!rstn) disp_en |-> not_full
    ) else $error("dispatch into a full rob");

endmodule

// ==== design/rob_core_top.sv ====
// back end top level
// rename and free list feed the rob, the rob commits into the arf
// dispatch uses valid/ready, completion and retirement are strobes

`timescale 1ns/1ps

module rob_core_top import rob_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 disp_valid,
    input  logic [AREG_W-1:0]    disp_areg,
    input  logic [DATA_W-1:0]    disp_pc,
    output logic                 disp_ready,
    output logic [PREG_W-1:0]    disp_preg,
    output logic [ROB_IDX_W-1:0] disp_rob_idx,
    input  logic                 comp_valid_0,
    input  logic [ROB_IDX_W-1:0] comp_idx_0,
    input  logic [DATA_W-1:0]    comp_data_0,
    input  logic                 comp_valid_1,
    input  logic [ROB_IDX_W-1:0] comp_idx_1,
    input  logic [DATA_W-1:0]    comp_data_1,
    output logic                 ret_valid_0,
    output logic [AREG_W-1:0]    ret_areg_0,
    output logic [DATA_W-1:0]    ret_data_0,
    output logic [DATA_W-1:0]    ret_pc_0,
    output logic                 ret_valid_1,
    output logic [AREG_W-1:0]    ret_areg_1,
    output logic [DATA_W-1:0]    ret_data_1,
    output logic [DATA_W-1:0]    ret_pc_1,
    input  logic [AREG_W-1:0]    rd_areg,
    output logic [DATA_W-1:0]    rd_data
);

    logic              not_full;
    logic              disp_fire;
    logic [PREG_W-1:0] old_preg;
    logic              free_push_0, free_push_1;
    logic [PREG_W-1:0] free_preg_0, free_preg_1;
    logic              arf_we_0, arf_we_1;
    logic [AREG_W-1:0] arf_areg_0, arf_areg_1;
    logic [DATA_W-1:0] arf_data_0, arf_data_1;

    assign disp_ready = not_full;
    assign disp_fire  = disp_valid && not_full;

    free_list u_free_list (
        .clk, .rstn,
        .pop         (disp_fire),
        .push_0      (free_push_0),
        .push_1      (free_push_1),
        .push_preg_0 (free_preg_0),
        .push_preg_1 (free_preg_1),
        .head_preg   (disp_preg)
    );

    rename_map u_rename_map (
        .clk, .rstn,
        .rename_en   (disp_fire),
        .rename_areg (disp_areg),
        .new_preg    (disp_preg),
        .old_preg    (old_preg)
    );

    reorder_buffer u_rob (
        .clk, .rstn,
        .disp_en       (disp_fire),
        .disp_areg     (disp_areg),
        .disp_old_preg (old_preg),
        .disp_pc       (disp_pc),
        .not_full      (not_full),
        .tail_idx      (disp_rob_idx),
        .comp_valid_0, .comp_idx_0, .comp_data_0,
        .comp_valid_1, .comp_idx_1, .comp_data_1,
        .ret_valid_0, .ret_areg_0, .ret_data_0, .ret_pc_0,
        .ret_valid_1, .ret_areg_1, .ret_data_1, .ret_pc_1,
        .free_push_0, .free_preg_0, .free_push_1, .free_preg_1,
        .arf_we_0, .arf_areg_0, .arf_data_0,
        .arf_we_1, .arf_areg_1, .arf_data_1
    );

    arch_regfile u_arf (
        .clk, .rstn,
        .we_0      (arf_we_0),
        .wr_areg_0 (arf_areg_0),
        .wr_data_0 (arf_data_0),
        .we_1      (arf_we_1),
        .wr_areg_1 (arf_areg_1),
        .wr_data_1 (arf_data_1),
        .rd_areg   (rd_areg),
        .rd_data   (rd_data)
    );

endmodule

// ==== design/rob_pkg.sv ====
// widths and depths shared by the reorder buffer back end
// import with rob_pkg::* in the module header, testbench uses it too

package rob_pkg;

    ////////////////////////////////
    // datapath
    ////////////////////////////////
    localparam int DATA_W = 32;                // result values and pcs

    ////////////////////////////////
    // register spaces
    ////////////////////////////////
    localparam int NUM_AREGS = 32;
    localparam int AREG_W    = 5;
    localparam int NUM_PREGS = 64;
    localparam int PREG_W    = 6;

    // pregs not covered by the reset map start out free
    localparam int FREE_DEPTH = NUM_PREGS - NUM_AREGS;
    localparam int FREE_PTR_W = 5;             // index into free list storage
    localparam int FREE_CNT_W = FREE_PTR_W + 1; // count reaches FREE_DEPTH

    ////////////////////////////////
    // reorder buffer
    ////////////////////////////////
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = 4;
    localparam int ROB_CNT_W = ROB_IDX_W + 1;  // occupancy 0..ROB_DEPTH
    localparam int RETIRE_W  = 2;              // max retirements per cycle

endpackage

// ==== flist.f ====
design/rob_pkg.sv
design/free_list.sv
design/rename_map.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/rob_core_top.sv
bench/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the reorder buffer back end with Verilator and run the testbench
# the result comes from searching the log for the pass line

set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module rob_tb -o rob_tb_sim

# the simulation exits non-zero on failure, the log search decides
./obj_dir/rob_tb_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
